// ==== hw/softmax_pkg.sv ====
// shared constants of the softmax exponent pipeline, imported by every rtl block
`default_nettype none

package softmax_pkg;

	// bfloat16 word: sign, 8-bit exponent, 7-bit stored mantissa
	localparam int FP_W     = 16;
	localparam int EXP_W    = 8;
	localparam int MAN_W    = 7;
	localparam int EXP_BIAS = 127;

	// field positions inside a word
	localparam int SIGN_POS = FP_W - 1;
	localparam int EXP_POS  = MAN_W;     // lsb of the exponent field

	// vector geometry
	localparam int VEC_LEN = 8;
	localparam int IDX_W   = $clog2(VEC_LEN);

	// exponent table, index is sign bit plus 8-bit magnitude
	localparam int LUT_ADDR_W = 9;
	localparam int LUT_DEPTH  = 512;

	localparam int SHIFT_W = 8;    // cfg_shift width

endpackage

`default_nettype wire

// ==== hw/elem_if.sv ====
// link from the max stage to the subtract stage, one buffered element per cycle
`default_nettype none

interface elem_if;
	import softmax_pkg::*;

	logic [FP_W-1:0] elem;   // replayed element
	logic [FP_W-1:0] vmax;   // max of the vector being replayed
	logic            valid;
	logic            last;   // final element of the vector

	modport src (
		output elem,
		output vmax,
		output valid,
		output last
	);

	modport dst (
		input elem,
		input vmax,
		input valid,
		input last
	);

endinterface

`default_nettype wire

// ==== hw/fp_add.sv ====
// combinational bfloat16 adder, no denormals, truncating; used for subtract and accumulate
`default_nettype none

module fp_add (
	input  wire  [softmax_pkg::FP_W-1:0] a,
	input  wire  [softmax_pkg::FP_W-1:0] b,
	output logic [softmax_pkg::FP_W-1:0] y
);
	import softmax_pkg::*;

	logic             a_big;      // |a| >= |b|
	logic [FP_W-1:0]  big;
	logic [FP_W-1:0]  sml;
	logic             sub;        // signs differ
	logic [EXP_W-1:0] e_big;
	logic [EXP_W-1:0] e_sml;
	logic [EXP_W-1:0] e_diff;
	logic [MAN_W:0]   m_big;      // hidden one restored
	logic [MAN_W:0]   m_sml;
	logic [MAN_W:0]   m_align;    // small mantissa shifted to e_big
	logic [MAN_W+1:0] m_sum;      // carry on top
	logic [EXP_W-1:0] lz;
	logic [MAN_W:0]   m_norm;

	// leading zeros of a mantissa with hidden bit
	function automatic logic [EXP_W-1:0] lead_zeros(input logic [MAN_W:0] v);
		logic [EXP_W-1:0] n;
		logic             seen;
		n = '0;
		seen = 1'b0;
		for (int i = MAN_W; i >= 0; i--) begin
			if (v[i])
				seen = 1'b1;
			else if (!seen)
				n = n + 1'b1;
		end
		return n;
	endfunction

	//////////////////////////////////////////
	// order by magnitude and align
	//////////////////////////////////////////

	// exponent:mantissa compares as a magnitude
	assign a_big = a[FP_W-2:0] >= b[FP_W-2:0];
	assign big   = a_big ? a : b;
	assign sml   = a_big ? b : a;
	assign sub   = big[SIGN_POS] ^ sml[SIGN_POS];

	assign e_big   = big[EXP_POS +: EXP_W];
	assign e_sml   = sml[EXP_POS +: EXP_W];
	assign m_big   = {1'b1, big[MAN_W-1:0]};
	assign m_sml   = {1'b1, sml[MAN_W-1:0]};
	assign e_diff  = e_big - e_sml;
	assign m_align = m_sml >> e_diff;    // bits shifted out are dropped

	// magnitudes ordered, so the subtract never goes negative
	assign m_sum  = sub ? {1'b0, m_big} - {1'b0, m_align} : {1'b0, m_big} + {1'b0, m_align};
	assign lz     = lead_zeros(m_sum[MAN_W:0]);
	assign m_norm = m_sum[MAN_W:0] << lz;

	//////////////////////////////////////////
	// normalize
	//////////////////////////////////////////

	always_comb begin
		if (e_big == '0) begin
			y = '0;                                  // both operands zero
		end else if (e_sml == '0 || e_diff > EXP_W'(MAN_W)) begin
			y = big;                                 // small one is lost anyway
		end else if (!sub) begin
			if (m_sum[MAN_W+1])
				y = {big[SIGN_POS], e_big + 1'b1, m_sum[MAN_W:1]};   // carry, shift right
			else
				y = {big[SIGN_POS], e_big, m_sum[MAN_W-1:0]};
		end else if (m_sum == '0) begin
			y = '0;                                  // exact cancellation
		end else if (lz >= e_big) begin
			y = '0;                                  // underflow, flush
		end else begin
			y = {big[SIGN_POS], e_big - lz, m_norm[MAN_W-1:0]};
		end
	end

endmodule

`default_nettype wire

// ==== hw/max_stage.sv ====
// first pipeline stage, buffers each input vector, finds its max and replays the elements
`default_nettype none

module max_stage (
	input  wire                          clk,
	input  wire                          rst,
	input  wire  [softmax_pkg::FP_W-1:0] idata,
	input  wire                          idata_valid,
	elem_if.src                          out
);
	import softmax_pkg::*;

	logic [FP_W-1:0]  elem_buf [VEC_LEN];
	logic [IDX_W-1:0] wr_idx;
	logic             wr_last;     // input closes a vector
	logic [FP_W-1:0]  run_max;
	logic [FP_W-1:0]  max_now;     // running max with idata folded in
	logic [FP_W-1:0]  vmax_q;
	logic [IDX_W-1:0] rd_idx;
	logic             rd_active;
	logic             rd_end;

	// signed ordering: sign first, then exponent, then mantissa
	function automatic logic fp_gt(input logic [FP_W-1:0] x, input logic [FP_W-1:0] y);
		logic mag_gt;
		logic mag_lt;
		mag_gt = {x[EXP_POS +: EXP_W], x[MAN_W-1:0]} > {y[EXP_POS +: EXP_W], y[MAN_W-1:0]};
		mag_lt = {x[EXP_POS +: EXP_W], x[MAN_W-1:0]} < {y[EXP_POS +: EXP_W], y[MAN_W-1:0]};
		if (x[SIGN_POS] != y[SIGN_POS])
			return y[SIGN_POS];                     // positive beats negative
		else if (x[SIGN_POS])
			return mag_lt;                          // both negative, smaller magnitude wins
		else
			return mag_gt;
	endfunction

	//////////////////////////////////////////
	// write side and running max
	//////////////////////////////////////////

	assign wr_last = idata_valid && wr_idx == IDX_W'(VEC_LEN - 1);
	// first element of a vector seeds the max
	assign max_now = (wr_idx == '0 || fp_gt(idata, run_max)) ? idata : run_max;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_idx <= '0;
		end else if (idata_valid) begin
			wr_idx <= wr_last ? '0 : wr_idx + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (idata_valid) begin
			elem_buf[wr_idx] <= idata;
			run_max <= max_now;
		end
		if (wr_last)
			vmax_q <= max_now;    // held for the whole replay
	end

	//////////////////////////////////////////
	// replay
	//////////////////////////////////////////

	assign rd_end = rd_idx == IDX_W'(VEC_LEN - 1);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rd_active <= 1'b0;
			rd_idx <= '0;
		end else if (wr_last) begin
			rd_active <= 1'b1;     // vector complete, start from entry 0
			rd_idx <= '0;
		end else if (rd_active) begin
			rd_active <= !rd_end;
			rd_idx <= rd_end ? '0 : rd_idx + 1'b1;
		end
	end

	// old entry is read before a following vector overwrites it at the same edge
	assign out.elem  = elem_buf[rd_idx];
	assign out.vmax  = vmax_q;
	assign out.valid = rd_active;
	assign out.last  = rd_active && rd_end;

	// a following vector must never overtake the replay in the buffer
	a_rd_ahead: assert property (@(posedge clk) disable iff (rst)
		rd_active |-> rd_idx >= wr_idx);

endmodule

`default_nettype wire

// ==== hw/shift_stage.sv ====
// subtracts the vector max from each element and turns the difference into a LUT index
`default_nettype none

module shift_stage (
	input  wire                                clk,
	input  wire                                rst,
	input  wire  [softmax_pkg::SHIFT_W-1:0]    cfg_shift,
	elem_if.dst                                in,
	output logic [softmax_pkg::LUT_ADDR_W-1:0] lut_idx,
	output logic                               idx_valid,
	output logic                               idx_last
);
	import softmax_pkg::*;

	logic [FP_W-1:0]           neg_max;
	logic [FP_W-1:0]           diff;
	logic [FP_W-1:0]           diff_q;
	logic                      diff_valid;
	logic                      diff_last;
	logic [EXP_W-1:0]          d_exp;
	logic [MAN_W:0]            d_man;     // hidden one restored
	logic signed [SHIFT_W+1:0] amt;       // right shift, may go negative
	logic [MAN_W+1:0]          shifted;   // integer part above the round bit
	logic [LUT_ADDR_W-2:0]     mag;
	logic [LUT_ADDR_W-1:0]     idx;

	//////////////////////////////////////////
	// step 1: elem - vmax
	//////////////////////////////////////////

	assign neg_max = {~in.vmax[SIGN_POS], in.vmax[FP_W-2:0]};

	fp_add u_sub (
		.a (in.elem),
		.b (neg_max),
		.y (diff)
	);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			diff_valid <= 1'b0;
			diff_last <= 1'b0;
		end else begin
			diff_valid <= in.valid;
			diff_last <= in.valid && in.last;
		end
	end

	always_ff @(posedge clk) begin
		if (in.valid)
			diff_q <= diff;
	end

	//////////////////////////////////////////
	// step 2: float to table index
	//////////////////////////////////////////

	assign d_exp = diff_q[EXP_POS +: EXP_W];
	assign d_man = {1'b1, diff_q[MAN_W-1:0]};
	assign amt   = (SHIFT_W+2)'(cfg_shift) + (SHIFT_W+2)'(EXP_BIAS) - (SHIFT_W+2)'(d_exp);

	always_comb begin
		shifted = '0;
		mag = '0;
		if (d_exp != '0) begin
			if (amt < 0) begin
				mag = '1;                   // past the top of the table, clamp
			end else if (amt <= MAN_W) begin
				shifted = {d_man, 1'b0} >> amt;
				mag = shifted[MAN_W+1:1] + shifted[0];   // round on last bit out
			end
		end
	end

	assign idx = (d_exp == '0) ? '0 : {diff_q[SIGN_POS], mag};   // zero diff is index 0

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			idx_valid <= 1'b0;
			idx_last <= 1'b0;
		end else begin
			idx_valid <= diff_valid;
			idx_last <= diff_valid && diff_last;
		end
	end

	always_ff @(posedge clk) begin
		if (diff_valid)
			lut_idx <= idx;
	end

endmodule

`default_nettype wire

// ==== hw/exp_lut.sv ====
// programmable exponent table, one port shared by host writes and pipeline reads
`default_nettype none

module exp_lut (
	input  wire                                clk,
	input  wire                                rst,
	input  wire  [softmax_pkg::LUT_ADDR_W-1:0] lut_waddr,
	input  wire                                lut_wen,
	input  wire  [softmax_pkg::FP_W-1:0]       lut_wdata,
	input  wire  [softmax_pkg::LUT_ADDR_W-1:0] lut_idx,
	input  wire                                idx_valid,
	input  wire                                idx_last,
	output logic [softmax_pkg::FP_W-1:0]       rdata,
	output logic                               rd_valid,
	output logic                               rd_last
);
	import softmax_pkg::*;

	logic [FP_W-1:0]       mem [LUT_DEPTH];
	logic [LUT_ADDR_W-1:0] addr;
	logic                  rd_en;

	assign addr  = lut_wen ? lut_waddr : lut_idx;   // write takes the port
	assign rd_en = idx_valid && !lut_wen;

	always_ff @(posedge clk) begin
		if (lut_wen)
			mem[addr] <= lut_wdata;
		else if (rd_en)
			rdata <= mem[addr];
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rd_valid <= 1'b0;
			rd_last <= 1'b0;
		end else begin
			rd_valid <= rd_en;
			rd_last <= rd_en && idx_last;
		end
	end

	// table is only reloaded while no vector is in flight
	a_no_wr_in_flight: assert property (@(posedge clk) disable iff (rst)
		!(lut_wen && idx_valid));

endmodule

`default_nettype wire

// ==== hw/sum_stage.sv ====
// output stage that registers the exponent stream and accumulates each vector's sum
`default_nettype none

module sum_stage (
	input  wire                          clk,
	input  wire                          rst,
	input  wire  [softmax_pkg::FP_W-1:0] rdata,
	input  wire                          rd_valid,
	input  wire                          rd_last,
	output logic [softmax_pkg::FP_W-1:0] odata,
	output logic                         odata_valid,
	output logic                         odata_last,
	output logic [softmax_pkg::FP_W-1:0] sum
);
	import softmax_pkg::*;

	logic [FP_W-1:0] acc_sum;   // sum + new exponent
	logic            first;     // next exponent opens a vector

	fp_add u_acc (
		.a (rdata),
		.b (sum),
		.y (acc_sum)
	);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			odata_valid <= 1'b0;
			odata_last <= 1'b0;
			first <= 1'b1;
			sum <= '0;
		end else begin
			odata_valid <= rd_valid;
			odata_last <= rd_last;
			if (rd_valid) begin
				first <= rd_last;
				sum <= first ? rdata : acc_sum;   // restart on a new vector
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rd_valid)
			odata <= rdata;
	end

	a_last_has_valid: assert property (@(posedge clk) disable iff (rst)
		odata_last |-> odata_valid);

endmodule

`default_nettype wire

// ==== hw/softmax_top.sv ====
// softmax exponent pipeline top: max, subtract and index, LUT read, sum
`default_nettype none

module softmax_top (
	input  wire                                clk,
	input  wire                                rst,
	input  wire  [softmax_pkg::SHIFT_W-1:0]    cfg_shift,
	input  wire  [softmax_pkg::LUT_ADDR_W-1:0] lut_waddr,
	input  wire                                lut_wen,
	input  wire  [softmax_pkg::FP_W-1:0]       lut_wdata,
	input  wire  [softmax_pkg::FP_W-1:0]       idata,
	input  wire                                idata_valid,
	output wire  [softmax_pkg::FP_W-1:0]       odata,
	output wire                                odata_valid,
	output wire                                odata_last,
	output wire  [softmax_pkg::FP_W-1:0]       sum
);
	import softmax_pkg::*;

	wire [LUT_ADDR_W-1:0] lut_idx;
	wire                  idx_valid;
	wire                  idx_last;
	wire [FP_W-1:0]       rdata;
	wire                  rd_valid;
	wire                  rd_last;

	elem_if elem_link ();

	max_stage u_max (
		.clk         (clk),
		.rst         (rst),
		.idata       (idata),
		.idata_valid (idata_valid),
		.out         (elem_link.src)
	);

	shift_stage u_shift (
		.clk       (clk),
		.rst       (rst),
		.cfg_shift (cfg_shift),
		.in        (elem_link.dst),
		.lut_idx   (lut_idx),
		.idx_valid (idx_valid),
		.idx_last  (idx_last)
	);

	exp_lut u_lut (
		.clk       (clk),
		.rst       (rst),
		.lut_waddr (lut_waddr),
		.lut_wen   (lut_wen),
		.lut_wdata (lut_wdata),
		.lut_idx   (lut_idx),
		.idx_valid (idx_valid),
		.idx_last  (idx_last),
		.rdata     (rdata),
		.rd_valid  (rd_valid),
		.rd_last   (rd_last)
	);

	sum_stage u_sum (
		.clk         (clk),
		.rst         (rst),
		.rdata       (rdata),
		.rd_valid    (rd_valid),
		.rd_last     (rd_last),
		.odata       (odata),
		.odata_valid (odata_valid),
		.odata_last  (odata_last),
		.sum         (sum)
	);

endmodule

`default_nettype wire

// ==== dv/softmax_vectors.svh ====
// vector table for the softmax testbench, included inside the testbench module
`ifndef SOFTMAX_VECTORS_SVH
`define SOFTMAX_VECTORS_SVH

// one row per vector: cfg_shift, VEC_LEN inputs, VEC_LEN expected outputs, expected sum
// rows with equal cfg_shift are sent back to back
localparam int NUM_ROWS = 4;

// shift 7 gives idx = round(|d|), shift 8 gives idx = round(|d| / 2)
localparam logic [SHIFT_W-1:0] ROW_SHIFT [NUM_ROWS] = '{8'd7, 8'd7, 8'd8, 8'd8};

localparam logic [FP_W-1:0] ROW_IN [NUM_ROWS][VEC_LEN] = '{
	// 2 4 -1 3 0.5 1 -2 4, max 4
	'{16'h4000, 16'h4080, 16'hBF80, 16'h4040, 16'h3F00, 16'h3F80, 16'hC000, 16'h4080},
	// -3 -1 -2 -5 -1 -4 -6 -3, all negative, max -1
	'{16'hC040, 16'hBF80, 16'hC000, 16'hC0A0, 16'hBF80, 16'hC080, 16'hC0C0, 16'hC040},
	'{16'h4000, 16'h4080, 16'hBF80, 16'h4040, 16'h3F00, 16'h3F80, 16'hC000, 16'h4080},
	'{16'hC040, 16'hBF80, 16'hC000, 16'hC0A0, 16'hBF80, 16'hC080, 16'hC0C0, 16'hC040}
};

// output is 2^-(idx mod 8)
localparam logic [FP_W-1:0] ROW_EXP [NUM_ROWS][VEC_LEN] = '{
	// d = -2 0 -5 -1 -3.5 -3 -6 0, idx 2 0 5 1 4 3 6 0
	'{16'h3E80, 16'h3F80, 16'h3D00, 16'h3F00, 16'h3D80, 16'h3E00, 16'h3C80, 16'h3F80},
	// d = -2 0 -1 -4 0 -3 -5 -2, idx 2 0 1 4 0 3 5 2
	'{16'h3E80, 16'h3F80, 16'h3F00, 16'h3D80, 16'h3F80, 16'h3E00, 16'h3D00, 16'h3E80},
	// halved: idx 1 0 3 0 2 2 3 0 (half rounds up, |d| < 2 is 0)
	'{16'h3F00, 16'h3F80, 16'h3E00, 16'h3F80, 16'h3E80, 16'h3E80, 16'h3E00, 16'h3F80},
	// halved: idx 1 0 0 2 0 2 3 1
	'{16'h3F00, 16'h3F80, 16'h3F80, 16'h3E80, 16'h3F80, 16'h3E80, 16'h3E00, 16'h3F00}
};

// 2.984375, 3.21875, 4.25, 4.625; every partial sum fits in 8 significant bits
localparam logic [FP_W-1:0] ROW_SUM [NUM_ROWS] = '{16'h403F, 16'h404E, 16'h4088, 16'h4094};

`endif

// ==== dv/softmax_tb.sv ====
// testbench for the softmax exponent pipeline that loads the LUT and checks table vectors
`default_nettype none

module softmax_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import softmax_pkg::*;

	localparam int NUM_PASSES    = 2;      // back to back pass and random gap pass
	localparam int LATENCY       = 5;      // last input edge to first output edge
	localparam int DRAIN_TIMEOUT = 100;

	`include "softmax_vectors.svh"

	logic                  clk;
	logic                  rst;
	logic [SHIFT_W-1:0]    cfg_shift;
	logic [LUT_ADDR_W-1:0] lut_waddr;
	logic                  lut_wen;
	logic [FP_W-1:0]       lut_wdata;
	logic [FP_W-1:0]       idata;
	logic                  idata_valid;
	wire  [FP_W-1:0]       odata;
	wire                   odata_valid;
	wire                   odata_last;
	wire  [FP_W-1:0]       sum;

	int seed = 94376;
	int vec_sent = 0;      // vectors fully driven
	int vec_done = 0;      // vectors fully received
	int cyc = 0;           // edge count
	int in_cnt = 0;
	int out_idx = 0;       // position inside the current output vector
	int last_in_cyc [NUM_PASSES*NUM_ROWS];

	softmax_top DUT (
		.clk         (clk),
		.rst         (rst),
		.cfg_shift   (cfg_shift),
		.lut_waddr   (lut_waddr),
		.lut_wen     (lut_wen),
		.lut_wdata   (lut_wdata),
		.idata       (idata),
		.idata_valid (idata_valid),
		.odata       (odata),
		.odata_valid (odata_valid),
		.odata_last  (odata_last),
		.sum         (sum)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic check_value(input logic [FP_W-1:0] got, input logic [FP_W-1:0] expected,
			input string what);
		if (got !== expected) begin
			$display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, expected);
			$display("Test FAILED");
			$fatal(1, "stopped at the first error");
		end
	endtask

	// 2^-(a mod 8) on the negative half and 1.0 on the positive half
	function automatic logic [FP_W-1:0] lut_entry(input int addr);
		logic [EXP_W-1:0] e;
		if (addr[LUT_ADDR_W-1])
			e = EXP_W'(EXP_BIAS - addr % 8);
		else
			e = EXP_W'(EXP_BIAS);
		return {1'b0, e, MAN_W'(0)};
	endfunction

	////////////////////////////////////////
	// drivers
	////////////////////////////////////////

	task automatic load_lut();
		int addr;
		for (addr = 0; addr < LUT_DEPTH; addr++) begin
			lut_wen <= 1'b1;
			lut_waddr <= LUT_ADDR_W'(addr);
			lut_wdata <= lut_entry(addr);
			@(posedge clk);
		end
		lut_wen <= 1'b0;
	endtask

	task automatic send_row(input int row, input bit gaps);
		int k;
		int idle;
		for (k = 0; k < VEC_LEN; k++) begin
			idle = gaps ? ($random(seed) & 3) : 0;   // 0 to 3 idle cycles
			repeat (idle) begin
				idata_valid <= 1'b0;
				@(posedge clk);
			end
			idata <= ROW_IN[row][k];
			idata_valid <= 1'b1;
			@(posedge clk);
		end
		vec_sent++;
	endtask

	// idle the input until every sent vector came out
	task automatic wait_drained();
		int cycles;
		cycles = 0;
		idata_valid <= 1'b0;
		while (vec_done != vec_sent) begin
			@(posedge clk);
			cycles++;
			if (cycles > DRAIN_TIMEOUT) begin
				$display("no result for vector %0d after %0d cycles", vec_done, cycles);
				$display("Test FAILED");
				$fatal(1, "timeout waiting for the output stream");
			end
		end
	endtask

	////////////////////////////////////////
	// output monitor
	////////////////////////////////////////

	always @(posedge clk) begin
		int row;
		row = vec_done % NUM_ROWS;
		cyc <= cyc + 1;
		if (!rst && idata_valid) begin
			if (in_cnt % VEC_LEN == VEC_LEN - 1)
				last_in_cyc[in_cnt / VEC_LEN] <= cyc;   // edge that closes the vector
			in_cnt <= in_cnt + 1;
		end
		if (!rst && odata_valid) begin
			check_value(FP_W'(vec_done < vec_sent), FP_W'(1), "output with a vector pending");
			check_value(odata, ROW_EXP[row][out_idx],
				$sformatf("odata row %0d elem %0d", row, out_idx));
			if (out_idx == 0)
				check_value(FP_W'(cyc - last_in_cyc[vec_done]), FP_W'(LATENCY), "latency");
			check_value(FP_W'(odata_last), FP_W'(out_idx == VEC_LEN - 1), "odata_last");
			if (out_idx == VEC_LEN - 1) begin
				check_value(sum, ROW_SUM[row], $sformatf("sum row %0d", row));
				out_idx <= 0;
				vec_done <= vec_done + 1;
			end else begin
				out_idx <= out_idx + 1;
			end
		end
	end

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial begin
		int pass;
		int row;
		rst = 1'b1;
		cfg_shift = '0;
		lut_waddr = '0;
		lut_wen = 1'b0;
		lut_wdata = '0;
		idata = '0;
		idata_valid = 1'b0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		load_lut();
		for (pass = 0; pass < NUM_PASSES; pass++) begin
			for (row = 0; row < NUM_ROWS; row++) begin
				// shift only changes with the pipeline empty
				if (cfg_shift != ROW_SHIFT[row]) begin
					wait_drained();
					cfg_shift <= ROW_SHIFT[row];
				end
				send_row(row, pass == 1);
			end
		end
		wait_drained();
		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+dv
hw/softmax_pkg.sv
hw/elem_if.sv
hw/fp_add.sv
hw/max_stage.sv
hw/shift_stage.sv
hw/exp_lut.sv
hw/sum_stage.sv
hw/softmax_top.sv
dv/softmax_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the softmax testbench with Verilator and run it; the exit status is the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps \
	-f all.f --top-module softmax_tb -Mdir obj_dir &&
./obj_dir/Vsoftmax_tb ||
{ echo "softmax simulation did not pass"; exit 1; }
